/* vlog.f */
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_cfg_regs.sv
hdl/tlb_lookup_chan.sv
hdl/tlb_top.sv
test/tlb_tb.sv

/* test/tlb_tests.txt */
# W cfg_addr wdata resp | R cfg_addr rdata resp | T chan in_addr hit out_addr
# H chan in_addr hit out_addr cfg_addr wdata holds one result across a config write
# chan 0 is the read channel and 1 the write channel, all fields hex
R 00 00000000 0
R 3c 00000000 0
T 0 00001234 0 00000000
T 1 00001234 0 00000000
W 00 00000010 0
W 04 0000001f 0
W 08 00080000 0
W 0c 00000001 0
R 04 0000001f 0
R 0c 00000001 0
W 10 fff12345 0
W 1c fffffffc 0
R 10 00012345 0
R 1c 00000000 0
W 10 00000018 0
W 14 0000002f 0
W 18 00040000 0
W 1c 00000001 0
W 40 00000077 2
R 40 00000000 2
R 00 00000010 0
T 0 00015abc 1 80005abc
T 1 0001a123 1 8000a123
T 0 00025fff 1 4000dfff
T 1 00030000 0 00000000
W 20 00000100 0
W 24 0000010f 0
W 28 00000200 0
W 2c 00000003 0
W 30 00000100 0
W 34 000001ff 0
W 38 00000300 0
T 0 00105008 1 00205008
T 1 00105008 0 00000000
T 0 00150abc 0 00000000
W 3c 00000001 0
H 0 00015abc 1 80005abc 08 00090000
T 0 00015abc 1 90005abc
T 1 00105008 1 00305008
T 0 0002f001 1 40017001
T 1 00018000 1 90008000
T 0 00200000 0 00000000
T 1 00150abc 1 00350abc

/* test/tlb_tb.sv */
// ####################################################################
// Self-checking testbench for the translation table
// Reads test/tlb_tests.txt, so it runs from the project root
// Consecutive translation lines form one burst per channel, issued
// under random result back-pressure from a fixed-seed LCG
// ####################################################################

`include "tlb_macros.svh"

module tlb_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Cycles any single handshake may take
  localparam int TIMEOUT = 200;

  logic                       clk_i;
  logic                       arst_n_i;
  tlb_pkg::axil_req_t         cfg_req;
  tlb_pkg::axil_resp_t        cfg_resp;
  logic [`TLB_INP_ADDR_W-1:0] wr_req_addr;
  logic                       wr_req_valid;
  logic                       wr_req_ready;
  tlb_pkg::tlb_res_t          wr_res;
  logic                       wr_res_valid;
  logic                       wr_res_ready;
  logic [`TLB_INP_ADDR_W-1:0] rd_req_addr;
  logic                       rd_req_valid;
  logic                       rd_req_ready;
  tlb_pkg::tlb_res_t          rd_res;
  logic                       rd_res_valid;
  logic                       rd_res_ready;

  // Pending requests and expected results per channel
  logic [`TLB_INP_ADDR_W-1:0] rd_addr_q[$];
  logic [`TLB_INP_ADDR_W-1:0] wr_addr_q[$];
  tlb_pkg::tlb_res_t          rd_exp_q[$];
  tlb_pkg::tlb_res_t          wr_exp_q[$];

  logic [31:0] lcg_state;
  int          checks;
  int          value_errs;
  int          other_errs;
  bit          stalled;

  tlb_top tlb_top_i (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .cfg_req_i      ( cfg_req      ),
    .cfg_resp_o     ( cfg_resp     ),
    .wr_req_addr_i  ( wr_req_addr  ),
    .wr_req_valid_i ( wr_req_valid ),
    .wr_req_ready_o ( wr_req_ready ),
    .wr_res_o       ( wr_res       ),
    .wr_res_valid_o ( wr_res_valid ),
    .wr_res_ready_i ( wr_res_ready ),
    .rd_req_addr_i  ( rd_req_addr  ),
    .rd_req_valid_i ( rd_req_valid ),
    .rd_req_ready_o ( rd_req_ready ),
    .rd_res_o       ( rd_res       ),
    .rd_res_valid_o ( rd_res_valid ),
    .rd_res_ready_i ( rd_res_ready )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Defined bits of a config register, picked by its field slot
  function automatic logic [31:0] defined_bits(input logic [7:0] addr);
    if (addr[3:2] == 2'd3)
      return 32'h0000_0003;
    else
      return 32'h000f_ffff;
  endfunction

  task automatic check_res(input string name, input tlb_pkg::tlb_res_t exp,
                           input tlb_pkg::tlb_res_t act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_rdata(input string name, input logic [`TLB_CFG_DATA_W-1:0] exp,
                             input logic [`TLB_CFG_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic report_stall(input string what);
    other_errs++;
    stalled = 1'b1;
    $display("Timeout waiting for %s", what);
  endtask

  task automatic set_req(input bit ch, input logic valid, input logic [31:0] addr);
    if (ch) begin
      wr_req_valid <= valid;
      wr_req_addr  <= addr;
    end else begin
      rd_req_valid <= valid;
      rd_req_addr  <= addr;
    end
  endtask

  task automatic set_res_ready(input bit ch, input logic ready);
    if (ch)
      wr_res_ready <= ready;
    else
      rd_res_ready <= ready;
  endtask

  // AW and W together, then the B response
  task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int cnt;
    bit done;
    cfg_req.aw_addr  <= addr;
    cfg_req.w_data   <= data;
    cfg_req.aw_valid <= 1'b1;
    cfg_req.w_valid  <= 1'b1;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      done = cfg_resp.aw_ready && cfg_resp.w_ready;
    end
    cfg_req.aw_valid <= 1'b0;
    cfg_req.w_valid  <= 1'b0;
    if (!done) begin
      report_stall("config write address handshake");
      return;
    end
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      done = cfg_resp.b_valid;
    end
    if (done)
      check_resp("cfg_resp_o.b_resp", exp_resp, cfg_resp.b_resp);
    else
      report_stall("config write response");
  endtask

  task automatic cfg_read(input logic [7:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    int cnt;
    bit done;
    cfg_req.ar_addr  <= addr;
    cfg_req.ar_valid <= 1'b1;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      done = cfg_resp.ar_ready;
    end
    cfg_req.ar_valid <= 1'b0;
    if (!done) begin
      report_stall("config read address handshake");
      return;
    end
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      done = cfg_resp.r_valid;
    end
    if (done) begin
      check_rdata("cfg_resp_o.r_data", exp_data, cfg_resp.r_data);
      check_resp("cfg_resp_o.r_resp", exp_resp, cfg_resp.r_resp);
    end else begin
      report_stall("config read data");
    end
  endtask

  // Presents the queued addresses of one channel back to back
  task automatic drive_reqs(input bit ch);
    logic [31:0] addr;
    int          cnt;
    bit          done;
    while ((ch ? wr_addr_q.size() : rd_addr_q.size()) > 0 && !stalled) begin
      if (ch)
        addr = wr_addr_q.pop_front();
      else
        addr = rd_addr_q.pop_front();
      set_req(ch, 1'b1, addr);
      cnt  = 0;
      done = 1'b0;
      while (!done && cnt < TIMEOUT) begin
        @(posedge clk_i);
        cnt++;
        done = ch ? wr_req_ready : rd_req_ready;
      end
      if (!done)
        report_stall(ch ? "write channel request" : "read channel request");
    end
    set_req(ch, 1'b0, '0);
  endtask

  // Random res_ready, one expected result popped per transfer
  task automatic collect_results(input bit ch);
    tlb_pkg::tlb_res_t exp_res;
    logic [31:0]       rnd;
    int                cnt;
    cnt = 0;
    while ((ch ? wr_exp_q.size() : rd_exp_q.size()) > 0 && !stalled) begin
      rnd = lcg_next();
      set_res_ready(ch, rnd[16]);
      @(posedge clk_i);
      cnt++;
      if (ch && wr_res_valid && wr_res_ready) begin
        exp_res = wr_exp_q.pop_front();
        check_res("wr_res_o", exp_res, wr_res);
        cnt = 0;
      end else if (!ch && rd_res_valid && rd_res_ready) begin
        exp_res = rd_exp_q.pop_front();
        check_res("rd_res_o", exp_res, rd_res);
        cnt = 0;
      end else if (cnt >= TIMEOUT) begin
        report_stall(ch ? "write channel result" : "read channel result");
      end
    end
    set_res_ready(ch, 1'b1);
  endtask

  task automatic run_translations();
    fork
      drive_reqs(1'b0);
      collect_results(1'b0);
      drive_reqs(1'b1);
      collect_results(1'b1);
    join
  endtask

  // Captures one result under back-pressure, rewrites the table, then drains
  task automatic hold_across_write(input bit ch, input logic [31:0] addr,
                                   input tlb_pkg::tlb_res_t exp_res,
                                   input logic [7:0] cfg_addr, input logic [31:0] cfg_data);
    int cnt;
    bit done;
    set_res_ready(ch, 1'b0);
    set_req(ch, 1'b1, addr);
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      done = ch ? wr_req_ready : rd_req_ready;
    end
    set_req(ch, 1'b0, '0);
    if (!done) begin
      report_stall("request of the held result");
      return;
    end
    cfg_write(cfg_addr, cfg_data, tlb_pkg::AXIL_OKAY);
    set_res_ready(ch, 1'b1);
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      done = ch ? wr_res_valid : rd_res_valid;
    end
    if (done) begin
      check_res(ch ? "wr_res_o" : "rd_res_o", exp_res, ch ? wr_res : rd_res);
      // Rewritten register reads back with only its defined bits
      cfg_read(cfg_addr, cfg_data & defined_bits(cfg_addr), tlb_pkg::AXIL_OKAY);
    end else begin
      report_stall("held result");
    end
  endtask

  initial begin
    int                fd;
    int                n;
    int                c;
    logic [7:0]        kind;
    logic [31:0]       f1;
    logic [31:0]       f2;
    logic [31:0]       f3;
    logic [31:0]       f4;
    logic [31:0]       f5;
    logic [31:0]       f6;
    tlb_pkg::tlb_res_t exp_res;
    lcg_state  = 32'h4eef151c;
    checks     = 0;
    value_errs = 0;
    other_errs = 0;
    stalled    = 1'b0;
    arst_n_i       <= 1'b0;
    cfg_req        <= '0;
    cfg_req.w_strb <= '1;
    // Responses are always taken right away
    cfg_req.b_ready <= 1'b1;
    cfg_req.r_ready <= 1'b1;
    set_req(1'b0, 1'b0, '0);
    set_req(1'b1, 1'b0, '0);
    set_res_ready(1'b0, 1'b1);
    set_res_ready(1'b1, 1'b1);
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    // Config handshake outputs idle after reset
    check_rdata("cfg_resp_o handshake bits", '0,
                {cfg_resp.aw_ready, cfg_resp.w_ready, cfg_resp.b_valid,
                 cfg_resp.ar_ready, cfg_resp.r_valid});
    fd = $fopen("test/tlb_tests.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Cannot open test/tlb_tests.txt");
    end else begin
      while (!stalled && $fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": begin
            c = $fgetc(fd);
            while (c != "\n" && c != -1)
              c = $fgetc(fd);
          end
          "W", "R": begin
            n = $fscanf(fd, "%h %h %h", f1, f2, f3);
            run_translations();
            if (n != 3) begin
              other_errs++;
              $display("Malformed config line in the test file");
            end else if (kind == "W") begin
              cfg_write(f1[7:0], f2, f3[1:0]);
            end else begin
              cfg_read(f1[7:0], f2, f3[1:0]);
            end
          end
          "T": begin
            n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
            exp_res.hit  = f3[0];
            exp_res.addr = f4;
            if (n != 4) begin
              other_errs++;
              $display("Malformed translation line in the test file");
            end else if (f1[0]) begin
              wr_addr_q.push_back(f2);
              wr_exp_q.push_back(exp_res);
            end else begin
              rd_addr_q.push_back(f2);
              rd_exp_q.push_back(exp_res);
            end
          end
          "H": begin
            n = $fscanf(fd, "%h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
            exp_res.hit  = f3[0];
            exp_res.addr = f4;
            run_translations();
            if (n != 6) begin
              other_errs++;
              $display("Malformed hold line in the test file");
            end else begin
              hold_across_write(f1[0], f2, exp_res, f5[7:0], f6);
            end
          end
          default: begin
            other_errs++;
            $display("Unknown command %c in the test file", kind);
          end
        endcase
      end
      // Burst left at the end of the file
      run_translations();
      $fclose(fd);
    end
    if (checks < 2) begin
      other_errs++;
      $display("No tests were run from the test file");
    end
    $display("Checks: %0d, value errors: %0d, other failures: %0d",
             checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* hdl/tlb_top.sv */
// ####################################################################
// Single-level address translation for a bus bridge
// One AXI4-Lite config port fills the shared table
// Read and write channels translate independently with valid/ready
// Translation has zero latency without back-pressure
// ####################################################################

`include "tlb_macros.svh"

module tlb_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Config port
  input  tlb_pkg::axil_req_t         cfg_req_i,
  output tlb_pkg::axil_resp_t        cfg_resp_o,
  // Write channel
  input  logic [`TLB_INP_ADDR_W-1:0] wr_req_addr_i,
  input  logic                       wr_req_valid_i,
  output logic                       wr_req_ready_o,
  output tlb_pkg::tlb_res_t          wr_res_o,
  output logic                       wr_res_valid_o,
  input  logic                       wr_res_ready_i,
  // Read channel
  input  logic [`TLB_INP_ADDR_W-1:0] rd_req_addr_i,
  input  logic                       rd_req_valid_i,
  output logic                       rd_req_ready_o,
  output tlb_pkg::tlb_res_t          rd_res_o,
  output logic                       rd_res_valid_o,
  input  logic                       rd_res_ready_i
);

  // Table shared by both channels
  tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries;

  tlb_cfg_regs i_cfg_regs (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .cfg_req_i  ( cfg_req_i  ),
    .cfg_resp_o ( cfg_resp_o ),
    .entries_o  ( entries    )
  );

  // Write channel ignores read-only segments
  tlb_lookup_chan #(
    .IS_WRITE ( 1'b1 )
  ) i_wr_chan (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .entries_i   ( entries        ),
    .req_addr_i  ( wr_req_addr_i  ),
    .req_valid_i ( wr_req_valid_i ),
    .req_ready_o ( wr_req_ready_o ),
    .res_o       ( wr_res_o       ),
    .res_valid_o ( wr_res_valid_o ),
    .res_ready_i ( wr_res_ready_i )
  );

  tlb_lookup_chan #(
    .IS_WRITE ( 1'b0 )
  ) i_rd_chan (
    .clk_i       ( clk_i          ),
    .arst_n_i    ( arst_n_i       ),
    .entries_i   ( entries        ),
    .req_addr_i  ( rd_req_addr_i  ),
    .req_valid_i ( rd_req_valid_i ),
    .req_ready_o ( rd_req_ready_o ),
    .res_o       ( rd_res_o       ),
    .res_valid_o ( rd_res_valid_o ),
    .res_ready_i ( rd_res_ready_i )
  );

endmodule

/* hdl/tlb_lookup_chan.sv */
// ####################################################################
// One translation channel with a combinational lookup
// Lowest matching entry index wins when segments overlap
// A one-deep fall-through stage holds a result under back-pressure, so
// table writes do not touch a result already waiting downstream
// With the stage full, req_ready_o stays low until the result is taken
// ####################################################################

`include "tlb_macros.svh"

module tlb_lookup_chan #(
  // Write channel skips read-only entries
  parameter bit IS_WRITE = 1'b0
) (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries_i,
  input  logic [`TLB_INP_ADDR_W-1:0]                 req_addr_i,
  input  logic                                       req_valid_i,
  output logic                                       req_ready_o,
  output tlb_pkg::tlb_res_t                          res_o,
  output logic                                       res_valid_o,
  input  logic                                       res_ready_i
);

  localparam int unsigned IDX_W = (`TLB_NUM_ENTRIES > 1) ? $clog2(`TLB_NUM_ENTRIES) : 1;

  tlb_pkg::inp_page_t            req_page;
  logic [`TLB_NUM_ENTRIES-1:0]   match;
  logic [IDX_W-1:0]              match_idx;
  logic                          any_match;
  tlb_pkg::tlb_entry_t           hit_entry;
  tlb_pkg::oup_page_t            oup_page;
  tlb_pkg::tlb_res_t             lookup_res;

  // Output stage
  logic              full_q;
  tlb_pkg::tlb_res_t res_q;

  // Only the page number takes part in the match
  assign req_page = req_addr_i[`TLB_INP_ADDR_W-1:`TLB_PAGE_SHIFT];

  // Range check per entry, last page is inclusive
  for (genvar i = 0; i < `TLB_NUM_ENTRIES; i++) begin : gen_match
    assign match[i] = entries_i[i].valid
        && (req_page >= entries_i[i].first)
        && (req_page <= entries_i[i].last)
        && (!IS_WRITE || !entries_i[i].read_only);
  end

  // Walk down from the top so the lowest match is the one left standing
  always_comb begin
    match_idx = '0;
    any_match = 1'b0;
    for (int i = `TLB_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        match_idx = IDX_W'(i);
        any_match = 1'b1;
      end
    end
  end

  assign hit_entry = entries_i[match_idx];

  // Output page = base + distance from the segment start
  always_comb begin
    oup_page = hit_entry.base + tlb_pkg::oup_page_t'(req_page - hit_entry.first);
    lookup_res.hit = any_match;
    if (any_match) begin
      // In-page offset bits pass through untouched
      lookup_res.addr = {oup_page, req_addr_i[`TLB_PAGE_SHIFT-1:0]};
    end else begin
      lookup_res.addr = '0;
    end
  end

  // Empty stage lets the lookup fall straight through
  assign res_valid_o = full_q || req_valid_i;
  assign res_o       = full_q ? res_q : lookup_res;
  // A request is taken whenever the stage has room for it
  assign req_ready_o = !full_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Drains when downstream takes the held result
      if (res_ready_i) begin
        full_q <= 1'b0;
      end
    end else if (req_valid_i && !res_ready_i) begin
      full_q <= 1'b1;
    end
  end

  // Result frozen at capture, later table writes do not reach it
  always_ff @(posedge clk_i) begin
    if (!full_q && req_valid_i && !res_ready_i) begin
      res_q <= lookup_res;
    end
  end

endmodule

/* hdl/tlb_cfg_regs.sv */
// ####################################################################
// AXI4-Lite slave holding the translation table
// One transaction at a time, a pending write wins over a read
// Write strobes are ignored, every write replaces the whole field
// Addresses past the table get SLVERR, writes there are dropped and
// reads return zero
// ####################################################################

`include "tlb_macros.svh"

module tlb_cfg_regs (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  tlb_pkg::axil_req_t                         cfg_req_i,
  output tlb_pkg::axil_resp_t                        cfg_resp_o,
  output tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries_o
);

  localparam int unsigned IDX_W = (`TLB_NUM_ENTRIES > 1) ? $clog2(`TLB_NUM_ENTRIES) : 1;
  // Each entry occupies four 32-bit registers
  localparam int unsigned TABLE_BYTES = `TLB_NUM_ENTRIES * 16;

  tlb_pkg::cfg_state_e state_q;
  tlb_pkg::cfg_state_e state_d;

  tlb_pkg::tlb_entry_t [`TLB_NUM_ENTRIES-1:0] entries_q;

  // Address decode for both directions
  logic [IDX_W-1:0]    wr_idx;
  logic [IDX_W-1:0]    rd_idx;
  tlb_pkg::cfg_field_e wr_field;
  tlb_pkg::cfg_field_e rd_field;
  logic                wr_in_range;
  logic                rd_in_range;

  // Handshake strobes, high for exactly one cycle
  logic wr_hs;
  logic rd_hs;

  logic [`TLB_CFG_DATA_W-1:0] rd_data;

  // Held response payload
  logic [1:0]                 b_resp_q;
  logic [`TLB_CFG_DATA_W-1:0] r_data_q;
  logic [1:0]                 r_resp_q;

  // Byte address = entry * 16 + field * 4
  assign wr_idx      = cfg_req_i.aw_addr[4 +: IDX_W];
  assign rd_idx      = cfg_req_i.ar_addr[4 +: IDX_W];
  assign wr_field    = tlb_pkg::cfg_field_e'(cfg_req_i.aw_addr[3:2]);
  assign rd_field    = tlb_pkg::cfg_field_e'(cfg_req_i.ar_addr[3:2]);
  assign wr_in_range = 32'(cfg_req_i.aw_addr) < TABLE_BYTES;
  assign rd_in_range = 32'(cfg_req_i.ar_addr) < TABLE_BYTES;

  // Next state and handshake strobes
  always_comb begin
    state_d = state_q;
    wr_hs   = 1'b0;
    rd_hs   = 1'b0;
    case (state_q)
      tlb_pkg::CFG_IDLE: begin
        // AW and W are taken together in one cycle
        if (cfg_req_i.aw_valid && cfg_req_i.w_valid) begin
          wr_hs   = 1'b1;
          state_d = tlb_pkg::CFG_WR_RESP;
        end else if (cfg_req_i.ar_valid && !cfg_req_i.aw_valid && !cfg_req_i.w_valid) begin
          // Reads wait while any part of a write is offered
          rd_hs   = 1'b1;
          state_d = tlb_pkg::CFG_RD_RESP;
        end
      end
      tlb_pkg::CFG_WR_RESP: begin
        if (cfg_req_i.b_ready) begin
          state_d = tlb_pkg::CFG_IDLE;
        end
      end
      tlb_pkg::CFG_RD_RESP: begin
        if (cfg_req_i.r_ready) begin
          state_d = tlb_pkg::CFG_IDLE;
        end
      end
      default: begin
        state_d = tlb_pkg::CFG_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= tlb_pkg::CFG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Table storage, all entries invalid after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entries_q <= '0;
    end else if (wr_hs && wr_in_range) begin
      unique case (wr_field)
        tlb_pkg::FIELD_FIRST: begin
          entries_q[wr_idx].first <= cfg_req_i.w_data[tlb_pkg::INP_PAGE_W-1:0];
        end
        tlb_pkg::FIELD_LAST: begin
          entries_q[wr_idx].last <= cfg_req_i.w_data[tlb_pkg::INP_PAGE_W-1:0];
        end
        tlb_pkg::FIELD_BASE: begin
          entries_q[wr_idx].base <= cfg_req_i.w_data[tlb_pkg::OUP_PAGE_W-1:0];
        end
        tlb_pkg::FIELD_FLAGS: begin
          entries_q[wr_idx].valid     <= cfg_req_i.w_data[0];
          entries_q[wr_idx].read_only <= cfg_req_i.w_data[1];
        end
      endcase
    end
  end

  // Readback mux, undefined bits read as zero
  always_comb begin
    rd_data = '0;
    unique case (rd_field)
      tlb_pkg::FIELD_FIRST: rd_data[tlb_pkg::INP_PAGE_W-1:0] = entries_q[rd_idx].first;
      tlb_pkg::FIELD_LAST:  rd_data[tlb_pkg::INP_PAGE_W-1:0] = entries_q[rd_idx].last;
      tlb_pkg::FIELD_BASE:  rd_data[tlb_pkg::OUP_PAGE_W-1:0] = entries_q[rd_idx].base;
      tlb_pkg::FIELD_FLAGS: rd_data[1:0] = {entries_q[rd_idx].read_only, entries_q[rd_idx].valid};
    endcase
    if (!rd_in_range) begin
      rd_data = '0;
    end
  end

  // Response payload captured at the address handshake
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      b_resp_q <= wr_in_range ? tlb_pkg::AXIL_OKAY : tlb_pkg::AXIL_SLVERR;
    end
    if (rd_hs) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_in_range ? tlb_pkg::AXIL_OKAY : tlb_pkg::AXIL_SLVERR;
    end
  end

  assign cfg_resp_o.aw_ready = wr_hs;
  assign cfg_resp_o.w_ready  = wr_hs;
  assign cfg_resp_o.b_valid  = (state_q == tlb_pkg::CFG_WR_RESP);
  assign cfg_resp_o.b_resp   = b_resp_q;
  assign cfg_resp_o.ar_ready = rd_hs;
  assign cfg_resp_o.r_valid  = (state_q == tlb_pkg::CFG_RD_RESP);
  assign cfg_resp_o.r_data   = r_data_q;
  assign cfg_resp_o.r_resp   = r_resp_q;

  // New entries reach both channels one cycle after the handshake
  assign entries_o = entries_q;

endmodule

/* hdl/tlb_pkg.sv */
// ####################################################################
// Shared types of the translation table
// Page numbers are the address bits above TLB_PAGE_SHIFT
// Config port structs carry only the AXI4-Lite signals the slave uses
// No prot signals are modeled
// ####################################################################

`include "tlb_macros.svh"

package tlb_pkg;

  // Page number widths in both address spaces
  localparam int unsigned INP_PAGE_W = `TLB_INP_ADDR_W - `TLB_PAGE_SHIFT;
  localparam int unsigned OUP_PAGE_W = `TLB_OUP_ADDR_W - `TLB_PAGE_SHIFT;

  typedef logic [INP_PAGE_W-1:0] inp_page_t;
  typedef logic [OUP_PAGE_W-1:0] oup_page_t;

  // AXI4-Lite response codes
  localparam logic [1:0] AXIL_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_SLVERR = 2'b10;

  // Master side of the config port
  typedef struct packed {
    logic [`TLB_CFG_ADDR_W-1:0]   aw_addr;
    logic                         aw_valid;
    logic [`TLB_CFG_DATA_W-1:0]   w_data;
    logic [`TLB_CFG_DATA_W/8-1:0] w_strb;
    logic                         w_valid;
    logic                         b_ready;
    logic [`TLB_CFG_ADDR_W-1:0]   ar_addr;
    logic                         ar_valid;
    logic                         r_ready;
  } axil_req_t;

  // Slave side of the config port
  typedef struct packed {
    logic                       aw_ready;
    logic                       w_ready;
    logic [1:0]                 b_resp;
    logic                       b_valid;
    logic                       ar_ready;
    logic [`TLB_CFG_DATA_W-1:0] r_data;
    logic [1:0]                 r_resp;
    logic                       r_valid;
  } axil_resp_t;

  // One segment, input pages first..last map onto output pages from base
  typedef struct packed {
    logic      read_only;
    logic      valid;
    oup_page_t base;
    inp_page_t last;
    inp_page_t first;
  } tlb_entry_t;

  // Translation result, addr is zero on a miss
  typedef struct packed {
    logic                       hit;
    logic [`TLB_OUP_ADDR_W-1:0] addr;
  } tlb_res_t;

  // Config port FSM
  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_WR_RESP,
    CFG_RD_RESP
  } cfg_state_e;

  // Register slot inside one 16-byte entry window
  typedef enum logic [1:0] {
    FIELD_FIRST,
    FIELD_LAST,
    FIELD_BASE,
    FIELD_FLAGS
  } cfg_field_e;

endpackage

/* hdl/tlb_macros.svh */
// ####################################################################
// Size and width settings of the translation table
// Page granularity is 4 KiB, so TLB_PAGE_SHIFT stays at 12
// Both address widths must be larger than TLB_PAGE_SHIFT
// Each entry takes 16 bytes of config space, so TLB_CFG_ADDR_W must
// cover TLB_NUM_ENTRIES * 16
// ####################################################################

`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// Number of segments in the table
`define TLB_NUM_ENTRIES 4

// Input and output address space widths
`define TLB_INP_ADDR_W 32
`define TLB_OUP_ADDR_W 32

// In-page offset bits, never translated
`define TLB_PAGE_SHIFT 12

// AXI4-Lite config port widths
`define TLB_CFG_ADDR_W 8
`define TLB_CFG_DATA_W 32

`endif
